// ==== Makefile ====
TOP = tb_icache

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module icache_top

sim:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -o sim_icache
	./obj_dir/sim_icache > sim.log
	cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== instr_mem.hex ====
// one 16-bit instruction word per line for word addresses 0 to 63
80FF
81FE
82FD
83FC
84FB
85FA
86F9
87F8
88F7
89F6
8AF5
8BF4
8CF3
8DF2
8EF1
8FF0
90EF
91EE
92ED
93EC
94EB
95EA
96E9
97E8
98E7
99E6
9AE5
9BE4
9CE3
9DE2
9EE1
9FE0
A0DF
A1DE
A2DD
A3DC
A4DB
A5DA
A6D9
A7D8
A8D7
A9D6
AAD5
ABD4
ACD3
ADD2
AED1
AFD0
B0CF
B1CE
B2CD
B3CC
B4CB
B5CA
B6C9
B7C8
B8C7
B9C6
BAC5
BBC4
BCC3
BDC2
BEC1
BFC0

// ==== logic/cache_line_store.sv ====
module cache_line_store
    import cache_pkg::*;
#(
    parameter type entry_t = line_t,
    parameter int ENTRIES = LINES
) (
    input  logic       clk,
    input  logic       reset_n,
    input  store_req_t req,
    input  entry_t     wdata,
    output entry_t     rdata
);

    entry_t entries [ENTRIES];

    // read is combinational at the requested index
    assign rdata = entries[req.index];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            // clears the valid bits of the tag store
            for (int i = 0; i < ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (req.we) begin
            entries[req.index] <= wdata;
        end
    end

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    import mem_pkg::*;

    // direct mapped geometry
    localparam int LINES = 4;
    localparam int WORDS_PER_LINE = FILL_WORDS;
    localparam int INDEX_W = $clog2(LINES);
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE);

    // tag is whatever is left above index and offset
    localparam int TAG_W = WORD_W - INDEX_W - OFFSET_W;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    // word 0 of the line sits in the low bits
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    // access to tag or data store
    typedef struct packed {
        logic               we;
        logic [INDEX_W-1:0] index;
    } store_req_t;

    // fetch unit to cache, held until ready
    typedef struct packed {
        logic              req;
        logic [WORD_W-1:0] addr;
    } fetch_req_t;

    // cache to fetch unit, single-cycle pulse
    typedef struct packed {
        logic              ready;
        logic [WORD_W-1:0] data;
    } fetch_rsp_t;

endpackage

// ==== logic/fetch_unit.sv ====
module fetch_unit
    import mem_pkg::*, cache_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              run,
    input  logic              redirect_valid,
    input  logic [WORD_W-1:0] redirect_pc,
    output fetch_req_t        fetch_req,
    input  fetch_rsp_t        fetch_rsp,
    output logic              instr_valid,
    output logic [WORD_W-1:0] instr_addr,
    output logic [WORD_W-1:0] instr
);

    logic [WORD_W-1:0] pc;
    logic              pending;
    logic              delivered;

    assign delivered = pending && fetch_rsp.ready;

    // request level and address come straight from registers
    assign fetch_req.req  = pending;
    assign fetch_req.addr = pc;

    // delivery is visible in the same cycle as the ready pulse
    assign instr_valid = delivered;
    assign instr_addr  = pc;
    assign instr       = fetch_rsp.data;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc      <= '0;
            pending <= 1'b0;
        end else if (delivered) begin
            // next request goes out right away if run is still high
            pending <= run;
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else begin
                pc <= pc + 1'b1;
            end
        end else if (!pending) begin
            pending <= run;
        end
    end

endmodule

// ==== logic/icache_ctrl.sv ====
module icache_ctrl
    import mem_pkg::*, cache_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    output store_req_t tag_req,
    output tag_entry_t tag_wdata,
    input  tag_entry_t tag_rdata,
    output store_req_t data_req,
    output line_t      data_wdata,
    input  line_t      data_rdata,
    output fill_req_t  fill_req,
    input  fill_rsp_t  fill_rsp
);

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE
    } state_t;

    state_t state;
    state_t state_next;

    logic [TAG_W-1:0]    req_tag;
    logic [INDEX_W-1:0]  req_index;
    logic [OFFSET_W-1:0] req_offset;
    logic                hit;

    // address split: tag | index | word offset
    assign req_tag    = fetch_req.addr[WORD_W-1 -: TAG_W];
    assign req_index  = fetch_req.addr[OFFSET_W +: INDEX_W];
    assign req_offset = fetch_req.addr[OFFSET_W-1:0];

    assign hit = tag_rdata.valid && (tag_rdata.tag == req_tag);

    always_comb begin
        state_next = state;

        // both stores are read at the request index by default
        tag_req.we     = 1'b0;
        tag_req.index  = req_index;
        data_req.we    = 1'b0;
        data_req.index = req_index;

        // new tag on allocation, returned line on fill
        tag_wdata.valid = 1'b1;
        tag_wdata.tag   = req_tag;
        data_wdata      = fill_rsp.line;

        fetch_rsp.ready = 1'b0;
        fetch_rsp.data  = data_rdata[req_offset];

        // line aligned fill address
        fill_req.rd   = 1'b0;
        fill_req.addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

        case (state)
            IDLE: begin
                if (fetch_req.req) begin
                    state_next = COMPARE;
                end
            end

            COMPARE: begin
                if (hit) begin
                    fetch_rsp.ready = 1'b1;
                    state_next      = IDLE;
                end else begin
                    // claim the line and ask memory for it
                    tag_req.we  = 1'b1;
                    fill_req.rd = 1'b1;
                    state_next  = ALLOCATE;
                end
            end

            ALLOCATE: begin
                // one fill in flight, wait for its ready pulse
                if (fill_rsp.ready) begin
                    data_req.we = 1'b1;
                    state_next  = COMPARE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== logic/icache_top.sv ====
module icache_top
    import mem_pkg::*, cache_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              run,
    input  logic              redirect_valid,
    input  logic [WORD_W-1:0] redirect_pc,
    output logic              instr_valid,
    output logic [WORD_W-1:0] instr_addr,
    output logic [WORD_W-1:0] instr
);

    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    store_req_t tag_req;
    tag_entry_t tag_wdata;
    tag_entry_t tag_rdata;
    store_req_t data_req;
    line_t      data_wdata;
    line_t      data_rdata;
    fill_req_t  fill_req;
    fill_rsp_t  fill_rsp;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .reset_n        (reset_n),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_req      (fetch_req),
        .fetch_rsp      (fetch_rsp),
        .instr_valid    (instr_valid),
        .instr_addr     (instr_addr),
        .instr          (instr)
    );

    icache_ctrl u_icache_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch_req  (fetch_req),
        .fetch_rsp  (fetch_rsp),
        .tag_req    (tag_req),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .data_req   (data_req),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .fill_req   (fill_req),
        .fill_rsp   (fill_rsp)
    );

    // tag store
    cache_line_store #(
        .entry_t (tag_entry_t),
        .ENTRIES (LINES)
    ) u_tag_store (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (tag_req),
        .wdata   (tag_wdata),
        .rdata   (tag_rdata)
    );

    // data store
    cache_line_store #(
        .entry_t (line_t),
        .ENTRIES (LINES)
    ) u_data_store (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (data_req),
        .wdata   (data_wdata),
        .rdata   (data_rdata)
    );

    line_fill_memory u_line_fill_memory (
        .clk      (clk),
        .reset_n  (reset_n),
        .fill_req (fill_req),
        .fill_rsp (fill_rsp)
    );

endmodule

// ==== logic/line_fill_memory.sv ====
module line_fill_memory
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  fill_req_t fill_req,
    output fill_rsp_t fill_rsp
);

    logic [WORD_W-1:0] mem [MEM_DEPTH];

    logic                               busy;
    logic [$clog2(MEM_LATENCY+1)-1:0]   count;
    logic [MEM_AW-1:0]                  base;

    initial begin
        $readmemh(MEM_FILE, mem);
    end

    // accept a strobe only while idle, then count down
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            busy           <= 1'b0;
            count          <= '0;
            fill_rsp.ready <= 1'b0;
        end else begin
            fill_rsp.ready <= 1'b0;
            if (busy) begin
                if (count == 1) begin
                    busy           <= 1'b0;
                    fill_rsp.ready <= 1'b1;
                    for (int i = 0; i < FILL_WORDS; i++) begin
                        fill_rsp.line[i] <= mem[base + MEM_AW'(i)];
                    end
                end else begin
                    count <= count - 1'b1;
                end
            end else if (fill_req.rd) begin
                busy  <= 1'b1;
                count <= ($clog2(MEM_LATENCY+1))'(MEM_LATENCY - 1);
                // higher address bits alias into the array
                base  <= fill_req.addr[MEM_AW-1:0];
            end
        end
    end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // instruction word and address width
    localparam int WORD_W = 16;

    // backing memory, addressed by the low address bits only
    localparam int MEM_DEPTH = 64;
    localparam int MEM_AW = $clog2(MEM_DEPTH);

    // cycles from read strobe to ready pulse
    localparam int MEM_LATENCY = 4;

    localparam string MEM_FILE = "instr_mem.hex";

    // words returned per fill
    localparam int FILL_WORDS = 4;

    typedef struct packed {
        logic              rd;
        logic [WORD_W-1:0] addr;
    } fill_req_t;

    typedef struct packed {
        logic                              ready;
        logic [FILL_WORDS-1:0][WORD_W-1:0] line;
    } fill_rsp_t;

endpackage

// ==== project.f ====
logic/mem_pkg.sv
logic/cache_pkg.sv
logic/cache_line_store.sv
logic/fetch_unit.sv
logic/icache_ctrl.sv
logic/line_fill_memory.sv
logic/icache_top.sv
tests/tb_clock.sv
tests/tb_icache.sv

// ==== tests/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // low for the first 16 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

// ==== tests/tb_icache.sv ====
module tb_icache
    import mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // cycles allowed for one fetch including misses
    localparam int FETCH_TIMEOUT = 50;

    logic              clk;
    logic              reset_n;
    logic              run;
    logic              redirect_valid;
    logic [WORD_W-1:0] redirect_pc;
    logic              instr_valid;
    logic [WORD_W-1:0] instr_addr;
    logic [WORD_W-1:0] instr;

    logic [WORD_W-1:0] model_mem [MEM_DEPTH];
    logic [WORD_W-1:0] expected_pc = '0;
    logic [31:0]       rng = 32'h40e182c0;
    int                errors = 0;
    int                model_count = 0;
    int                dut_count = 0;

    tb_clock u_tb_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    icache_top u_icache_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .run            (run),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr_valid    (instr_valid),
        .instr_addr     (instr_addr),
        .instr          (instr)
    );

    // counts every delivery apart from the fetch sequence
    always @(negedge clk) begin
        if (instr_valid === 1'b1) begin
            dut_count++;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_instr(output bit arrived);
        int cycles;
        arrived = 1'b0;
        cycles = 0;
        while (!arrived && cycles < FETCH_TIMEOUT) begin
            @(negedge clk);
            arrived = (instr_valid === 1'b1);
            cycles++;
        end
        if (!arrived) begin
            $display("no instruction arrived within %0d cycles at %0t ns",
                     FETCH_TIMEOUT, $time);
            errors++;
        end
    endtask

    // a negative gap leaves run low after the delivery
    task automatic fetch_one(input logic redirect, input logic [WORD_W-1:0] target,
                             input int gap);
        bit arrived;
        wait_instr(arrived);
        if (arrived) begin
            check_value("instr_addr", 32'(expected_pc), 32'(instr_addr));
            check_value("instr", 32'(model_mem[expected_pc[MEM_AW-1:0]]), 32'(instr));
            model_count++;
            // redirect is taken in the delivery cycle
            redirect_valid = redirect;
            redirect_pc    = target;
            expected_pc    = redirect ? target : expected_pc + 1'b1;
            if (gap != 0) begin
                run = 1'b0;
            end
            @(negedge clk);
            redirect_valid = 1'b0;
            if (gap > 0) begin
                repeat (gap) @(negedge clk);
                run = 1'b1;
            end
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    initial begin
        int start;
        int cycles;
        int gap;

        // run is already high while reset is held
        run            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        $readmemh("instr_mem.hex", model_mem);

        // no delivery while reset is held and just after
        start = errors;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < 40) begin
            @(negedge clk);
            check_value("instr_valid", 32'h0, 32'(instr_valid));
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            $display("reset was never released");
            errors++;
        end
        repeat (4) begin
            @(negedge clk);
            check_value("instr_valid", 32'h0, 32'(instr_valid));
        end
        fetch_one(1'b1, 16'h0000, 0);
        report_test("reset", start);

        // 32 fetches from 0 across cold misses
        start = errors;
        for (int i = 0; i < 32; i++) begin
            fetch_one(i == 31, 16'h0000, 0);
        end
        report_test("sequential", start);

        // 0 to 15 refilled and then read again from the stored lines
        start = errors;
        for (int i = 0; i < 32; i++) begin
            fetch_one(i == 15, 16'h0000, 0);
        end
        report_test("reread", start);

        start = errors;
        for (int i = 0; i < 64; i++) begin
            rng = xorshift(rng);
            fetch_one(rng[1:0] == 2'b00, rng[31:16], 0);
        end
        report_test("redirect", start);

        start = errors;
        for (int i = 0; i < 48; i++) begin
            rng = xorshift(rng);
            gap = rng[2] ? int'(rng[5:3]) + 1 : 0;
            fetch_one(rng[9:7] == 3'b000, rng[31:16], gap);
        end
        fetch_one(1'b0, 16'h0000, -1);
        // nothing may arrive once run stays low
        repeat (20) @(negedge clk);
        @(posedge clk);
        check_value("delivered count", 32'(model_count), 32'(dut_count));
        report_test("pause", start);

        $display("%0d instructions checked, %0d errors", model_count, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
